//--- Makefile
TOOL       := verilator
TOP        := tb_cam_to_hdmi
FILELIST   := project.f
FLAGS      := --binary --timing --assert --timescale 1ns/10ps
LINT_FLAGS := --lint-only -Wall --timing --timescale 1ns/10ps
RUN_ARGS   := +verilator+error+limit+100
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := TEST FAILED
PASS_MSG   := TEST PASSED

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation ended without a result"; exit 1)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- project.f
+incdir+source
source/video_pkg.sv
source/pixel_fifo.sv
source/cam_capture.sv
source/sync_vg.sv
source/hdmi_display.sv
source/cam_to_hdmi_top.sv
sim/cam_to_hdmi_assertions.sv
sim/tb_cam_to_hdmi.sv

//--- sim/cam_to_hdmi_assertions.sv
`timescale 1ns/10ps
`include "video_defs.svh"

module cam_to_hdmi_assertions #(
    parameter int unsigned NORMAL_FRAMES = 3,
    localparam int PACK_W = 4 + 24 + `VID_X_BITS + `VID_Y_BITS
) (
    input logic              clk,
    input logic              rstn,
    input logic              i_frame_start,
    input logic [PACK_W-1:0] i_pack,
    input logic              i_overflow,
    input logic              i_underflow
);

    localparam int H_TOTAL = `VID_H_SYNC + `VID_H_BP + `VID_H_ACT + `VID_H_FP;
    localparam int VS_CLKS = `VID_V_SYNC * H_TOTAL;

    int unsigned fail_count = 0;
    int unsigned frames;
    int unsigned hs_len;
    int unsigned vs_len;
    logic        vs;
    logic        hs;

    assign vs = i_pack[PACK_W-1];
    assign hs = i_pack[PACK_W-2];

    // camera frames seen and current sync run lengths.
    always_ff @(posedge clk or negedge rstn) begin
        if (~rstn) begin
            frames <= '0;
            hs_len <= '0;
            vs_len <= '0;
        end else begin
            if (i_frame_start) begin
                frames <= frames + 1;
            end
            hs_len <= hs ? hs_len + 1 : '0;
            vs_len <= vs ? vs_len + 1 : '0;
        end
    end

    quiet_before_first_frame: assert property (@(posedge clk) disable iff (~rstn)
        (frames == 0) |-> (i_pack == '0))
        else begin
            $error("packed output active before the first camera frame");
            fail_count++;
        end

    hsync_width: assert property (@(posedge clk) disable iff (~rstn)
        $fell(hs) |-> (hs_len == `VID_H_SYNC))
        else begin
            $error("packed hsync width wrong");
            fail_count++;
        end

    vsync_width: assert property (@(posedge clk) disable iff (~rstn)
        $fell(vs) |-> (vs_len == VS_CLKS))
        else begin
            $error("packed vsync width wrong");
            fail_count++;
        end

    no_overflow: assert property (@(posedge clk) disable iff (~rstn) !i_overflow)
        else begin
            $error("fifo overflow flag set");
            fail_count++;
        end

    no_underflow_normal: assert property (@(posedge clk) disable iff (~rstn)
        (frames <= NORMAL_FRAMES) |-> !i_underflow)
        else begin
            $error("fifo underflow during a normal frame");
            fail_count++;
        end

    underflow_sticky: assert property (@(posedge clk) disable iff (~rstn)
        i_underflow |=> i_underflow)
        else begin
            $error("underflow flag cleared without reset");
            fail_count++;
        end

endmodule : cam_to_hdmi_assertions

bind cam_to_hdmi_top cam_to_hdmi_assertions #(
    .NORMAL_FRAMES(3)
) u_assertions (
    .clk          (clk),
    .rstn         (rstn),
    .i_frame_start(frame_start),
    .i_pack       (o_pack),
    .i_overflow   (o_overflow),
    .i_underflow  (o_underflow)
);

//--- sim/tb_cam_to_hdmi.sv
`timescale 1ns/10ps
`include "video_defs.svh"

module tb_cam_to_hdmi;

    import video_pkg::*;

    localparam int H_TOTAL  = `VID_H_SYNC + `VID_H_BP + `VID_H_ACT + `VID_H_FP;
    localparam int V_TOTAL  = `VID_V_SYNC + `VID_V_BP + `VID_V_ACT + `VID_V_FP;
    localparam int V_START  = `VID_V_SYNC + `VID_V_BP;
    localparam int HREF_AT  = `VID_H_SYNC + `VID_H_BP - 4;    // camera runs a few pixels ahead.
    localparam int LATENCY  = 2 + V_START * H_TOTAL + `VID_H_SYNC + `VID_H_BP;
    localparam int PACK_W   = 4 + 24 + `VID_X_BITS + `VID_Y_BITS;
    localparam int FRAMES   = 4;                               // last one loses a line.
    localparam int WAIT_MAX = 2 * V_TOTAL * H_TOTAL;

    logic                   clk;
    logic                   rstn;
    logic                   cam_vsync;
    logic                   cam_href;
    rgb565_t                cam_data;
    logic [PACK_W-1:0]      pack;
    logic                   overflow;
    logic                   underflow;
    logic                   p_de;
    logic                   p_first;
    logic [23:0]            p_colour;
    logic [`VID_X_BITS-1:0] p_x;
    logic [`VID_Y_BITS-1:0] p_y;

    rgb565_t     exp_q[$];
    int unsigned cyc = 0;
    int unsigned vs_rise_cyc = 0;
    int unsigned n_checked = 0;
    int unsigned exp_x = 0;
    int unsigned exp_y = 0;
    bit          vs_sent = 1'b0;

    assign {p_de, p_first, p_colour, p_x, p_y} = pack[PACK_W-3:0];

    cam_to_hdmi_top UUT (
        .clk        (clk),
        .rstn       (rstn),
        .i_cam_vsync(cam_vsync),
        .i_cam_href (cam_href),
        .i_cam_data (cam_data),
        .o_pack     (pack),
        .o_overflow (overflow),
        .o_underflow(underflow)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        abort_run($sformatf("mismatch at %0t: %s got 0x%0h expected 0x%0h",
                            $time, name, got, want));
    endtask

    // each channel shifted up with zero fill.
    function automatic logic [23:0] expand_pixel(input rgb565_t p);
        return {p.r, 3'b000, p.g, 2'b00, p.b, 3'b000};
    endfunction

    task automatic check_pixel();
        rgb565_t px;
        bit      want_first;
        if (n_checked == 0 && int'(cyc - vs_rise_cyc) - 1 != LATENCY) begin
            report_mismatch("first de latency", 32'(cyc - vs_rise_cyc - 1), 32'(LATENCY));
        end
        if (exp_q.size() == 0) begin
            abort_run($sformatf("packed de at %0t with no camera pixel pending", $time));
        end
        px = exp_q.pop_front();
        want_first = (exp_x == 0) && (exp_y == 0);
        if (p_colour !== expand_pixel(px)) begin
            report_mismatch("o_pack.rgb", 32'(p_colour), 32'(expand_pixel(px)));
        end
        if (32'(p_x) !== exp_x) begin
            report_mismatch("o_pack.x", 32'(p_x), exp_x);
        end
        if (32'(p_y) !== exp_y) begin
            report_mismatch("o_pack.y", 32'(p_y), exp_y);
        end
        if (p_first !== want_first) begin
            report_mismatch("o_pack.first", 32'(p_first), 32'(want_first));
        end
        n_checked++;
        if (exp_x == `VID_H_ACT - 1) begin
            exp_x = 0;
            exp_y = (exp_y == `VID_V_ACT - 1) ? 0 : exp_y + 1;
        end else begin
            exp_x++;
        end
    endtask

    always @(negedge clk) begin
        if (rstn && p_de) begin
            check_pixel();
        end
        if (rstn && p_first && !p_de) begin
            abort_run($sformatf("frame-first flag set outside de at %0t", $time));
        end
        if (UUT.u_assertions.fail_count != 0) begin
            abort_run("a protocol assertion failed");
        end
    end

    // one vsync-aligned camera line; dropped lines leave href low.
    task automatic send_line(input logic vs, input bit active, input bit record, input bit drop);
        rgb565_t px;
        bit      in_win;
        for (int pos = 0; pos < H_TOTAL; pos++) begin
            @(negedge clk);
            px = rgb565_t'(16'($urandom));
            in_win = active && (pos >= HREF_AT) && (pos < HREF_AT + `VID_H_ACT);
            if (vs && !cam_vsync && !vs_sent) begin
                vs_rise_cyc = cyc;
                vs_sent = 1'b1;
            end
            cam_vsync = vs;
            cam_href = in_win && !drop;
            cam_data = cam_href ? px : rgb565_t'('0);
            if (record && in_win) begin
                exp_q.push_back(drop ? rgb565_t'('0) : px);   // empty reads give black.
            end
        end
    endtask

    task automatic send_frame(input bit drop_line);
        for (int ln = 0; ln < V_TOTAL; ln++) begin
            send_line(ln < `VID_V_SYNC, (ln >= V_START) && (ln < V_START + `VID_V_ACT),
                      1'b1, drop_line && (ln == V_START));
        end
    endtask

    task automatic wait_queue_drained();
        int n = 0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
            n++;
            if (n > WAIT_MAX) begin
                abort_run("timeout waiting for the display to consume the camera pixels");
            end
        end
    endtask

    task automatic wait_underflow();
        int n = 0;
        while (!underflow) begin
            @(negedge clk);
            n++;
            if (n > WAIT_MAX) begin
                abort_run("timeout waiting for the underflow flag");
            end
        end
    endtask

    initial begin
        rstn = 1'b0;
        cam_vsync = 1'b0;
        cam_href = 1'b0;
        cam_data = rgb565_t'('0);
        void'($urandom(32'hdec2ee97));
        repeat (4) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        repeat (3) @(negedge clk);
        send_line(1'b0, 1'b1, 1'b0, 1'b0);     // sent before the first vsync and never captured.
        for (int f = 0; f < FRAMES; f++) begin
            send_frame(f == FRAMES - 1);
        end
        wait_queue_drained();
        wait_underflow();
        if (overflow !== 1'b0) begin
            report_mismatch("o_overflow", 32'(overflow), 32'd0);
        end
        if (UUT.u_assertions.fail_count == 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            $display("TEST FAILED");
            $fatal(1, "protocol assertions reported errors");
        end
    end

endmodule : tb_cam_to_hdmi

//--- source/cam_capture.sv
`timescale 1ns/10ps

module cam_capture (
    input  logic               clk,
    input  logic               rstn,
    input  logic               i_cam_vsync,
    input  logic               i_cam_href,
    input  video_pkg::rgb565_t i_cam_data,
    output logic               o_wr_en,
    output video_pkg::rgb565_t o_wr_data,
    output logic               o_frame_start
);

    logic vsync_d;
    logic armed;

    // rising edge of the camera frame strobe.
    assign o_frame_start = i_cam_vsync & ~vsync_d;

    always_ff @(posedge clk or negedge rstn) begin
        if (~rstn) begin
            vsync_d <= 1'b0;
            armed   <= 1'b0;
        end else begin
            vsync_d <= i_cam_vsync;
            if (o_frame_start) begin
                armed <= 1'b1;            // stays set so the partial first frame is skipped.
            end
        end
    end

    // one write per pixel while the line is valid
    always_ff @(posedge clk or negedge rstn) begin
        if (~rstn) begin
            o_wr_en <= 1'b0;
        end else begin
            o_wr_en <= armed & i_cam_href;
        end
    end

    always_ff @(posedge clk) begin
        o_wr_data <= i_cam_data;          // qualified by o_wr_en.
    end

endmodule : cam_capture

//--- source/cam_to_hdmi_top.sv
`timescale 1ns/10ps
`include "video_defs.svh"

module cam_to_hdmi_top #(
    localparam int PACK_W = 4 + 24 + `VID_X_BITS + `VID_Y_BITS
) (
    input  logic               clk,
    input  logic               rstn,
    input  logic               i_cam_vsync,
    input  logic               i_cam_href,
    input  video_pkg::rgb565_t i_cam_data,
    output logic [PACK_W-1:0]  o_pack,
    output logic               o_overflow,
    output logic               o_underflow
);

    import video_pkg::*;

    logic    wr_en;
    rgb565_t wr_data;
    logic    rd_en;
    rgb565_t rd_data;
    logic    frame_start;

    cam_capture u_cam_capture (
        .clk          (clk),
        .rstn         (rstn),
        .i_cam_vsync  (i_cam_vsync),
        .i_cam_href   (i_cam_href),
        .i_cam_data   (i_cam_data),
        .o_wr_en      (wr_en),
        .o_wr_data    (wr_data),
        .o_frame_start(frame_start)
    );

    pixel_fifo #(
        .DEPTH(`VID_FIFO_DEPTH)
    ) u_pixel_fifo (
        .clk        (clk),
        .rstn       (rstn),
        .i_wr_en    (wr_en),
        .i_wr_data  (wr_data),
        .i_rd_en    (rd_en),
        .o_rd_data  (rd_data),
        .o_empty    (),
        .o_full     (),
        .o_overflow (o_overflow),
        .o_underflow(o_underflow)
    );

    hdmi_display #(
        .H_FP  (`VID_H_FP),
        .H_BP  (`VID_H_BP),
        .H_SYNC(`VID_H_SYNC),
        .H_ACT (`VID_H_ACT),
        .V_FP  (`VID_V_FP),
        .V_BP  (`VID_V_BP),
        .V_SYNC(`VID_V_SYNC),
        .V_ACT (`VID_V_ACT)
    ) u_hdmi_display (
        .clk          (clk),
        .rstn         (rstn),
        .i_frame_start(frame_start),
        .i_rd_data    (rd_data),
        .o_rd_en      (rd_en),
        .o_pack       (o_pack)
    );

endmodule : cam_to_hdmi_top

//--- source/hdmi_display.sv
`timescale 1ns/10ps
`include "video_defs.svh"

module hdmi_display #(
    parameter int H_FP   = `VID_H_FP,
    parameter int H_BP   = `VID_H_BP,
    parameter int H_SYNC = `VID_H_SYNC,
    parameter int H_ACT  = `VID_H_ACT,
    parameter int V_FP   = `VID_V_FP,
    parameter int V_BP   = `VID_V_BP,
    parameter int V_SYNC = `VID_V_SYNC,
    parameter int V_ACT  = `VID_V_ACT,
    localparam int PACK_W = 4 + 24 + `VID_X_BITS + `VID_Y_BITS
) (
    input  logic               clk,
    input  logic               rstn,
    input  logic               i_frame_start,
    input  video_pkg::rgb565_t i_rd_data,
    output logic               o_rd_en,
    output logic [PACK_W-1:0]  o_pack
);

    import video_pkg::*;

    logic                   run;
    logic                   vsync;
    logic                   hsync;
    logic                   de;
    logic [`VID_X_BITS-1:0] x;
    logic [`VID_Y_BITS-1:0] y;
    logic                   first;
    rgb888_t                colour;

    // display timing begins on the first camera frame and never stops.
    always_ff @(posedge clk or negedge rstn) begin
        if (~rstn) begin
            run <= 1'b0;
        end else if (i_frame_start) begin
            run <= 1'b1;
        end
    end

    sync_vg #(
        .H_FP  (H_FP),
        .H_BP  (H_BP),
        .H_SYNC(H_SYNC),
        .H_ACT (H_ACT),
        .V_FP  (V_FP),
        .V_BP  (V_BP),
        .V_SYNC(V_SYNC),
        .V_ACT (V_ACT),
        .X_BITS(`VID_X_BITS),
        .Y_BITS(`VID_Y_BITS)
    ) u_sync_vg (
        .clk    (clk),
        .rstn   (rstn),
        .i_run  (run),
        .o_vsync(vsync),
        .o_hsync(hsync),
        .o_de   (de),
        .o_x    (x),
        .o_y    (y)
    );

    assign o_rd_en = de;                  // one pixel per active clock.
    assign colour  = rgb565_to_888(i_rd_data);
    assign first   = de && (x == '0) && (y == '0);

    always_ff @(posedge clk or negedge rstn) begin
        if (~rstn) begin
            o_pack <= '0;
        end else begin
            o_pack <= {vsync, hsync, de, first, colour, x, y};
        end
    end

endmodule : hdmi_display

//--- source/pixel_fifo.sv
`timescale 1ns/10ps
`include "video_defs.svh"

module pixel_fifo #(
    parameter int DEPTH = `VID_FIFO_DEPTH
) (
    input  logic               clk,
    input  logic               rstn,
    input  logic               i_wr_en,
    input  video_pkg::rgb565_t i_wr_data,
    input  logic               i_rd_en,
    output video_pkg::rgb565_t o_rd_data,
    output logic               o_empty,
    output logic               o_full,
    output logic               o_overflow,
    output logic               o_underflow
);

    import video_pkg::*;

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    rgb565_t        mem [DEPTH];
    logic [AW-1:0]  wr_ptr;
    logic [AW-1:0]  rd_ptr;
    logic [AW:0]    count;
    logic           wr_ok;
    logic           rd_ok;

    assign o_empty = (count == '0);
    assign o_full  = (count == (AW+1)'(DEPTH));

    assign wr_ok = i_wr_en & ~o_full;     // a write into a full buffer is lost.
    assign rd_ok = i_rd_en & ~o_empty;

    // head is shown as soon as it is stored; nothing valid reads as black.
    assign o_rd_data = o_empty ? rgb565_t'('0) : mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= i_wr_data;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (~rstn) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            o_overflow  <= 1'b0;
            o_underflow <= 1'b0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (i_wr_en && o_full) begin
                o_overflow <= 1'b1;       // sticky until reset.
            end
            if (i_rd_en && o_empty) begin
                o_underflow <= 1'b1;      // sticky until reset.
            end
        end
    end

endmodule : pixel_fifo

//--- source/sync_vg.sv
`timescale 1ns/10ps
`include "video_defs.svh"

module sync_vg #(
    parameter int H_FP   = `VID_H_FP,
    parameter int H_BP   = `VID_H_BP,
    parameter int H_SYNC = `VID_H_SYNC,
    parameter int H_ACT  = `VID_H_ACT,
    parameter int V_FP   = `VID_V_FP,
    parameter int V_BP   = `VID_V_BP,
    parameter int V_SYNC = `VID_V_SYNC,
    parameter int V_ACT  = `VID_V_ACT,
    parameter int X_BITS = `VID_X_BITS,
    parameter int Y_BITS = `VID_Y_BITS
) (
    input  logic              clk,
    input  logic              rstn,
    input  logic              i_run,
    output logic              o_vsync,
    output logic              o_hsync,
    output logic              o_de,
    output logic [X_BITS-1:0] o_x,
    output logic [Y_BITS-1:0] o_y
);

    localparam int H_TOTAL = H_SYNC + H_BP + H_ACT + H_FP;
    localparam int V_TOTAL = V_SYNC + V_BP + V_ACT + V_FP;
    localparam int H_START = H_SYNC + H_BP;      // first active clock of a line.
    localparam int V_START = V_SYNC + V_BP;      // first active line of a frame.
    localparam int HW      = $clog2(H_TOTAL);
    localparam int VW      = $clog2(V_TOTAL);

    logic [HW-1:0] h_cnt;
    logic [VW-1:0] v_cnt;
    logic          h_end;
    logic          v_end;
    logic          h_act;
    logic          v_act;
    logic          de_next;

    assign h_end = (h_cnt == HW'(H_TOTAL - 1));
    assign v_end = (v_cnt == VW'(V_TOTAL - 1));

    // each line runs sync, back porch, active and front porch.
    always_ff @(posedge clk or negedge rstn) begin
        if (~rstn) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (~i_run) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_end) begin
            h_cnt <= '0;
            v_cnt <= v_end ? '0 : v_cnt + 1'b1;
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    assign h_act   = (h_cnt >= HW'(H_START)) && (h_cnt < HW'(H_START + H_ACT));
    assign v_act   = (v_cnt >= VW'(V_START)) && (v_cnt < VW'(V_START + V_ACT));
    assign de_next = i_run & h_act & v_act;

    // outputs held low until the generator is running.
    always_ff @(posedge clk or negedge rstn) begin
        if (~rstn) begin
            o_vsync <= 1'b0;
            o_hsync <= 1'b0;
            o_de    <= 1'b0;
            o_x     <= '0;
            o_y     <= '0;
        end else begin
            o_vsync <= i_run & (v_cnt < VW'(V_SYNC));
            o_hsync <= i_run & (h_cnt < HW'(H_SYNC));
            o_de    <= de_next;
            if (de_next) begin
                o_x <= X_BITS'(h_cnt - HW'(H_START));
                o_y <= Y_BITS'(v_cnt - VW'(V_START));
            end else begin
                o_x <= '0;
                o_y <= '0;
            end
        end
    end

endmodule : sync_vg

//--- source/video_defs.svh
`ifndef VIDEO_DEFS_SVH
`define VIDEO_DEFS_SVH

// horizontal timing in clocks is kept small for simulation.
`define VID_H_FP    32'd4
`define VID_H_BP    32'd6
`define VID_H_SYNC  32'd3
`define VID_H_ACT   32'd16

// vertical timing in lines.
`define VID_V_FP    32'd1
`define VID_V_BP    32'd2
`define VID_V_SYNC  32'd1
`define VID_V_ACT   32'd4

// active coordinate widths.
`define VID_X_BITS  11
`define VID_Y_BITS  10

// pixel buffer depth.
`define VID_FIFO_DEPTH  32

`endif

//--- source/video_pkg.sv
package video_pkg;

    // camera pixel with red in the low bits.
    typedef struct packed {
        logic [4:0] b;
        logic [5:0] g;
        logic [4:0] r;
    } rgb565_t;

    // display colour with red in the top byte.
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb888_t;

    // widen each channel by padding zero lsbs.
    function automatic rgb888_t rgb565_to_888(rgb565_t p);
        rgb888_t c;
        c.r = {p.r, 3'b000};
        c.g = {p.g, 2'b00};
        c.b = {p.b, 3'b000};
        return c;
    endfunction

endpackage : video_pkg
